//--- rammodel.f
rtl/rammodel_axi_pkg.sv
rtl/rammodel_cfg_pkg.sv
rtl/rammodel_req_queue.sv
rtl/rammodel_tm_fixed.sv
rtl/rammodel_mem.sv
rtl/rammodel_top.sv
sim/rammodel_clkgen.sv
sim/rammodel_tb.sv

//--- rtl/rammodel_axi_pkg.sv
package rammodel_axi_pkg;

    // AXI field widths
    localparam int id_width   = 4;
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int len_width  = 8;

    // one queued address request, shared by AR and AW
    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [addr_width-1:0] addr;
        logic [len_width-1:0]  len;   // beats minus one
    } axi_req_t;

endpackage

//--- rtl/rammodel_cfg_pkg.sv
package rammodel_cfg_pkg;

    // storage geometry
    localparam int mem_words      = 1024;   // depth in beats
    localparam int mem_addr_width = 10;

    // timing model delays, in clock cycles
    localparam int r_delay = 25;   // read accept to first beat
    localparam int w_delay = 3;    // wlast to write response

    localparam int queue_depth = 4;   // per request queue

endpackage

//--- rtl/rammodel_mem.sv
`timescale 1ns/1ps
`default_nettype none

module rammodel_mem (
    input  logic                                    clk,

    input  logic                                    rd_start,
    input  logic [rammodel_axi_pkg::addr_width-1:0] rd_addr,
    input  logic                                    rd_step,

    input  logic                                    wr_start,
    input  logic [rammodel_axi_pkg::addr_width-1:0] wr_addr,
    input  logic                                    wr_step,
    input  logic [rammodel_axi_pkg::data_width-1:0] wdata,
    input  logic [rammodel_axi_pkg::strb_width-1:0] wstrb,

    output logic [rammodel_axi_pkg::data_width-1:0] rdata
);

    localparam int lsb = $clog2(rammodel_axi_pkg::strb_width);   // byte offset bits

    logic [rammodel_axi_pkg::data_width-1:0] mem [rammodel_cfg_pkg::mem_words];

    logic [rammodel_cfg_pkg::mem_addr_width-1:0] rd_ptr;
    logic [rammodel_cfg_pkg::mem_addr_width-1:0] wr_ptr;

    // byte address to word index, wrapped to the depth
    function automatic logic [rammodel_cfg_pkg::mem_addr_width-1:0] word_index(
        input logic [rammodel_axi_pkg::addr_width-1:0] addr
    );
        return rammodel_cfg_pkg::mem_addr_width'(
            (addr >> lsb) % rammodel_cfg_pkg::mem_words);
    endfunction

    function automatic logic [rammodel_cfg_pkg::mem_addr_width-1:0] next_index(
        input logic [rammodel_cfg_pkg::mem_addr_width-1:0] idx
    );
        if (idx == rammodel_cfg_pkg::mem_addr_width'(rammodel_cfg_pkg::mem_words - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rd_start) begin
            rd_ptr <= word_index(rd_addr);
        end else if (rd_step) begin
            rd_ptr <= next_index(rd_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            wr_ptr <= word_index(wr_addr);
        end else if (wr_step) begin
            wr_ptr <= next_index(wr_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_step) begin
            for (int b = 0; b < rammodel_axi_pkg::strb_width; b++) begin
                if (wstrb[b]) begin
                    mem[wr_ptr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[rd_ptr];   // follows pointer same cycle

endmodule

`default_nettype wire

//--- rtl/rammodel_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module rammodel_req_queue #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    payload_t buffer [depth];

    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;

    logic push;
    logic pop;

    assign in_ready  = count != cnt_width'(depth);
    assign out_valid = count != '0;
    assign out_data  = buffer[rd_ptr];   // oldest entry

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rammodel_tm_fixed.sv
`timescale 1ns/1ps
`default_nettype none

module rammodel_tm_fixed (
    input  logic                                   clk,
    input  logic                                   rst,

    // read request queue head
    input  logic                                   rq_valid,
    output logic                                   rq_ready,
    input  logic [rammodel_axi_pkg::id_width-1:0]  rq_id,
    input  logic [rammodel_axi_pkg::len_width-1:0] rq_len,

    // write request queue head
    input  logic                                   wq_valid,
    output logic                                   wq_ready,
    input  logic [rammodel_axi_pkg::id_width-1:0]  wq_id,

    input  logic                                   wvalid,
    output logic                                   wready,
    input  logic                                   wlast,

    output logic                                   bvalid,
    input  logic                                   bready,
    output logic [rammodel_axi_pkg::id_width-1:0]  bid,

    output logic                                   rvalid,
    input  logic                                   rready,
    output logic                                   rlast,
    output logic [rammodel_axi_pkg::id_width-1:0]  rid,

    // strobes to the data store
    output logic                                   rd_start,
    output logic                                   rd_step,
    output logic                                   wr_start,
    output logic                                   wr_step
);

    localparam int rcnt_width = $clog2(rammodel_cfg_pkg::r_delay + 2);
    localparam int wcnt_width = $clog2(rammodel_cfg_pkg::w_delay + 2);

    logic rd_busy;   // read burst held
    logic wr_busy;   // write burst held
    logic wr_done;   // wlast seen, waiting on B

    logic [rcnt_width-1:0] rcnt;
    logic [wcnt_width-1:0] wcnt;

    logic [rammodel_axi_pkg::len_width-1:0] rlen;   // beats left minus one
    logic [rammodel_axi_pkg::id_width-1:0]  rid_q;
    logic [rammodel_axi_pkg::id_width-1:0]  bid_q;

    // read side
    assign rq_ready = !rd_busy;
    assign rd_start = rq_valid && !rd_busy;
    assign rvalid   = rd_busy && rcnt == '0;
    assign rlast    = rd_busy && rlen == '0;
    assign rid      = rid_q;
    assign rd_step  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            rcnt    <= '0;
        end else if (rd_start) begin
            rd_busy <= 1'b1;
            rcnt    <= rcnt_width'(rammodel_cfg_pkg::r_delay);
        end else begin
            if (rcnt != '0) begin
                rcnt <= rcnt - 1'b1;
            end
            if (rd_step && rlast) begin
                rd_busy <= 1'b0;   // slot frees after last beat
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            rlen  <= rq_len;
            rid_q <= rq_id;
        end else if (rd_step) begin
            rlen <= rlen - 1'b1;
        end
    end

    // write side
    assign wq_ready = !wr_busy;
    assign wr_start = wq_valid && !wr_busy;
    assign wready   = wr_busy && !wr_done;
    assign wr_step  = wvalid && wready;
    assign bvalid   = wr_done && wcnt == '0;
    assign bid      = bid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_busy <= 1'b0;
            wr_done <= 1'b0;
            wcnt    <= '0;
        end else begin
            if (wr_start) begin
                wr_busy <= 1'b1;
            end
            if (wr_step && wlast) begin
                wr_done <= 1'b1;
                wcnt    <= wcnt_width'(rammodel_cfg_pkg::w_delay);
            end else if (wcnt != '0) begin
                wcnt <= wcnt - 1'b1;
            end
            if (bvalid && bready) begin
                wr_busy <= 1'b0;
                wr_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            bid_q <= wq_id;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rammodel_top.sv
`timescale 1ns/1ps
`default_nettype none

module rammodel_top (
    input  logic                                    clk,
    input  logic                                    rst,

    input  logic                                    arvalid,
    output logic                                    arready,
    input  logic [rammodel_axi_pkg::id_width-1:0]   arid,
    input  logic [rammodel_axi_pkg::addr_width-1:0] araddr,
    input  logic [rammodel_axi_pkg::len_width-1:0]  arlen,

    input  logic                                    awvalid,
    output logic                                    awready,
    input  logic [rammodel_axi_pkg::id_width-1:0]   awid,
    input  logic [rammodel_axi_pkg::addr_width-1:0] awaddr,
    input  logic [rammodel_axi_pkg::len_width-1:0]  awlen,

    input  logic                                    wvalid,
    output logic                                    wready,
    input  logic [rammodel_axi_pkg::data_width-1:0] wdata,
    input  logic [rammodel_axi_pkg::strb_width-1:0] wstrb,
    input  logic                                    wlast,

    output logic                                    bvalid,
    input  logic                                    bready,
    output logic [rammodel_axi_pkg::id_width-1:0]   bid,

    output logic                                    rvalid,
    input  logic                                    rready,
    output logic [rammodel_axi_pkg::id_width-1:0]   rid,
    output logic [rammodel_axi_pkg::data_width-1:0] rdata,
    output logic                                    rlast
);

    rammodel_axi_pkg::axi_req_t ar_req;
    rammodel_axi_pkg::axi_req_t aw_req;
    rammodel_axi_pkg::axi_req_t rq_head;
    rammodel_axi_pkg::axi_req_t wq_head;

    logic rq_valid;
    logic rq_ready;
    logic wq_valid;
    logic wq_ready;
    logic rd_start;
    logic rd_step;
    logic wr_start;
    logic wr_step;

    assign ar_req = '{id: arid, addr: araddr, len: arlen};
    assign aw_req = '{id: awid, addr: awaddr, len: awlen};

    rammodel_req_queue #(
        .payload_t (rammodel_axi_pkg::axi_req_t),
        .depth     (rammodel_cfg_pkg::queue_depth)
    ) rd_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (arvalid),
        .in_ready  (arready),
        .in_data   (ar_req),
        .out_valid (rq_valid),
        .out_ready (rq_ready),
        .out_data  (rq_head)
    );

    rammodel_req_queue #(
        .payload_t (rammodel_axi_pkg::axi_req_t),
        .depth     (rammodel_cfg_pkg::queue_depth)
    ) wr_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (awvalid),
        .in_ready  (awready),
        .in_data   (aw_req),
        .out_valid (wq_valid),
        .out_ready (wq_ready),
        .out_data  (wq_head)
    );

    rammodel_tm_fixed u_tm (
        .clk      (clk),
        .rst      (rst),
        .rq_valid (rq_valid),
        .rq_ready (rq_ready),
        .rq_id    (rq_head.id),
        .rq_len   (rq_head.len),
        .wq_valid (wq_valid),
        .wq_ready (wq_ready),
        .wq_id    (wq_head.id),
        .wvalid   (wvalid),
        .wready   (wready),
        .wlast    (wlast),
        .bvalid   (bvalid),
        .bready   (bready),
        .bid      (bid),
        .rvalid   (rvalid),
        .rready   (rready),
        .rlast    (rlast),
        .rid      (rid),
        .rd_start (rd_start),
        .rd_step  (rd_step),
        .wr_start (wr_start),
        .wr_step  (wr_step)
    );

    // write length is tracked by wlast, so only addresses go to the store
    rammodel_mem u_mem (
        .clk      (clk),
        .rd_start (rd_start),
        .rd_addr  (rq_head.addr),
        .rd_step  (rd_step),
        .wr_start (wr_start),
        .wr_addr  (wq_head.addr),
        .wr_step  (wr_step),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f rammodel.f --top-module rammodel_tb \
    -o rammodel_sim && ./obj_dir/rammodel_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '*** PASSED ***' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sim/rammodel_clkgen.sv
`timescale 1ns/1ps

module rammodel_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;   // released just after the fourth edge
    end

endmodule

//--- sim/rammodel_tb.sv
`timescale 1ns/1ps

module rammodel_tb;

    localparam int num_tests = 12;
    localparam int words = rammodel_cfg_pkg::mem_words;

    logic clk, rst;
    logic arvalid, arready, awvalid, awready, wvalid, wready, wlast;
    logic bvalid, bready, rvalid, rready, rlast;
    logic [rammodel_axi_pkg::id_width-1:0] arid, awid, bid, rid;
    logic [rammodel_axi_pkg::addr_width-1:0] araddr, awaddr;
    logic [rammodel_axi_pkg::len_width-1:0] arlen, awlen;
    logic [rammodel_axi_pkg::data_width-1:0] wdata, rdata;
    logic [rammodel_axi_pkg::strb_width-1:0] wstrb;

    logic [31:0] lfsr = 32'd67299;
    logic random_ready;
    logic [rammodel_axi_pkg::data_width-1:0] ref_mem [words];
    logic [rammodel_axi_pkg::addr_width-1:0] wr_addr [num_tests];
    logic [rammodel_axi_pkg::len_width-1:0] wr_len [num_tests];

    rammodel_axi_pkg::axi_req_t ar_q[$], aw_q[$], cur_w;
    logic [rammodel_axi_pkg::id_width-1:0] b_id_q[$];
    int ar_cyc_q[$], b_cyc_q[$];
    int cyc, r_beat, w_beat, w_idx, ar_pend, b_pend, r_age, b_age;
    logic [rammodel_axi_pkg::data_width-1:0] exp_rdata, held_rdata;
    logic [rammodel_axi_pkg::id_width-1:0] exp_rid, exp_bid, held_bid;
    logic exp_rlast, r_stall = 1'b0, b_stall = 1'b0;

    rammodel_clkgen u_clkgen (.clk(clk), .rst(rst));
    rammodel_top UUT (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);   // one step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int word_of(input logic [rammodel_axi_pkg::addr_width-1:0] addr);
        return int'((addr / rammodel_axi_pkg::strb_width) % words);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    // ch 0 aw, 1 w, 2 ar; ready sampled mid-cycle
    task automatic wait_accept(input int ch);
        logic ok;
        do begin
            @(negedge clk);
            ok = (ch == 0) ? awready : (ch == 1) ? wready : arready;
            @(posedge clk);
            #1;
        end while (!ok);
    endtask

    task automatic write_burst(input int t, input logic full_strb);
        awvalid = 1'b1;
        awid = rammodel_axi_pkg::id_width'(rand_bits(rammodel_axi_pkg::id_width));
        awaddr = wr_addr[t];
        awlen = wr_len[t];
        wait_accept(0);
        awvalid = 1'b0;
        for (int beat = 0; beat <= int'(wr_len[t]); beat++) begin
            wvalid = 1'b1;
            wdata = rand_bits(32);
            wstrb = full_strb ? 4'hf : 4'(rand_bits(4));
            wlast = beat == int'(wr_len[t]);
            wait_accept(1);
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        while (b_pend != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        awvalid = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        random_ready = 1'b0;
        @(negedge rst);
        for (int t = 0; t < num_tests; t++) begin
            wr_addr[t] = rand_bits(32);
            wr_len[t] = rammodel_axi_pkg::len_width'(rand_bits(4));
        end
        wr_addr[0] = 32'h0000_0ff1;   // word 1020 so the burst wraps
        wr_len[0] = 7;
        random_ready = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            write_burst(t, 1'b1);
            write_burst(t, 1'b0);   // random strobes over known words
        end
        random_ready = 1'b0;   // rready low until the read queue fills
        for (int t = 0; t < num_tests; t++) begin
            if (t == rammodel_cfg_pkg::queue_depth + 1) begin
                random_ready = 1'b1;
            end
            arvalid = 1'b1;
            arid = rammodel_axi_pkg::id_width'(rand_bits(rammodel_axi_pkg::id_width));
            araddr = wr_addr[t];
            arlen = wr_len[t];
            wait_accept(2);
        end
        arvalid = 1'b0;
        while (ar_pend != 0) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        logic [31:0] bits;
        rready = 1'b0;
        bready = 1'b1;
        forever begin
            @(negedge clk);
            bits = rand_bits(4);
            @(posedge clk);
            #1;
            rready = random_ready && bits[1:0] != 2'b00;
            bready = !random_ready || bits[3:2] != 2'b00;
        end
    end

    initial begin
        repeat (num_tests * (rammodel_cfg_pkg::r_delay + 300)) @(posedge clk);
        fail_run("timeout: the run did not finish in time");
    end

    // reference model of the handshakes and the store
    always @(posedge clk) begin
        cyc++;
        if (!rst) begin
            if (arvalid && arready) begin
                ar_q.push_back({arid, araddr, arlen});
                ar_cyc_q.push_back(cyc);
            end
            if (awvalid && awready) begin
                aw_q.push_back({awid, awaddr, awlen});
            end
            if (wvalid && wready) begin
                if (w_beat == 0) begin
                    cur_w = aw_q.pop_front();
                    w_idx = word_of(cur_w.addr);
                end
                for (int b = 0; b < rammodel_axi_pkg::strb_width; b++) begin
                    if (wstrb[b]) begin
                        ref_mem[w_idx][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
                w_idx = (w_idx + 1) % words;   // wraps at the top
                if (wlast) begin
                    b_id_q.push_back(cur_w.id);
                    b_cyc_q.push_back(cyc);
                    w_beat = 0;
                end else begin
                    w_beat++;
                end
            end
            if (bvalid && bready && b_id_q.size() != 0) begin
                b_id_q.delete(0);
                b_cyc_q.delete(0);
            end
            if (rvalid && rready && ar_q.size() != 0) begin
                if (r_beat == int'(ar_q[0].len)) begin
                    ar_q.delete(0);
                    ar_cyc_q.delete(0);
                    r_beat = 0;
                end else begin
                    r_beat++;
                end
            end
            ar_pend = ar_q.size();
            b_pend = b_id_q.size();
            if (ar_pend != 0) begin
                exp_rid = ar_q[0].id;
                exp_rlast = r_beat == int'(ar_q[0].len);
                exp_rdata = ref_mem[(word_of(ar_q[0].addr) + r_beat) % words];
                r_age = cyc - ar_cyc_q[0];
            end
            if (b_pend != 0) begin
                exp_bid = b_id_q[0];
                b_age = cyc - b_cyc_q[0];
            end
            r_stall = rvalid && !rready;
            held_rdata = rdata;
            b_stall = bvalid && !bready;
            held_bid = bid;
        end
    end

    a_reset: assert property (@(posedge clk) $past(rst) && !rst |->
        arready && awready && !wready && !rvalid && !bvalid)
        else fail_run("wrong ready or valid level right after reset");
    a_r_order: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> ar_pend != 0 && (r_beat != 0 || r_age > rammodel_cfg_pkg::r_delay))
        else fail_run("read beat without a pending request or before the read delay");
    a_rdata: assert property (@(posedge clk) disable iff (rst) rvalid |-> rdata == exp_rdata)
        else fail_run($sformatf("mismatch rdata expected %h actual %h",
            $sampled(exp_rdata), $sampled(rdata)));
    a_rid: assert property (@(posedge clk) disable iff (rst) rvalid |-> rid == exp_rid)
        else fail_run($sformatf("mismatch rid expected %h actual %h",
            $sampled(exp_rid), $sampled(rid)));
    a_rlast: assert property (@(posedge clk) disable iff (rst) rvalid |-> rlast == exp_rlast)
        else fail_run($sformatf("mismatch rlast expected %h actual %h",
            $sampled(exp_rlast), $sampled(rlast)));
    a_b_order: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> b_pend != 0 && b_age >= rammodel_cfg_pkg::w_delay)
        else fail_run("write response without a finished burst or before the write delay");
    a_bid: assert property (@(posedge clk) disable iff (rst) bvalid |-> bid == exp_bid)
        else fail_run($sformatf("mismatch bid expected %h actual %h",
            $sampled(exp_bid), $sampled(bid)));
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        r_stall |-> rvalid && rdata == held_rdata)
        else fail_run($sformatf("mismatch rdata under back-pressure expected %h actual %h",
            $sampled(held_rdata), $sampled(rdata)));
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        b_stall |-> bvalid && bid == held_bid)
        else fail_run($sformatf("mismatch bid under back-pressure expected %h actual %h",
            $sampled(held_bid), $sampled(bid)));
    a_ar_full: assert property (@(posedge clk) disable iff (rst)
        ar_pend > rammodel_cfg_pkg::queue_depth |-> !arready)
        else fail_run($sformatf("mismatch arready expected %h actual %h",
            1'b0, $sampled(arready)));

endmodule
